//--- logic/store_cfg.svh
`ifndef STORE_CFG_SVH
`define STORE_CFG_SVH

// store instruction fields
`define OPC_STORE_5         5'b01000
`define FNC_SB              3'b000
`define FNC_SH              3'b001
`define FNC_SW              3'b010

// region select bits of the store address
`define DMEM_BIT            28
`define IMEM_BIT            29
`define IO_BIT              31

// system io offsets, window 0x8000_0xxx
`define IO_UART_TX          12'h008
`define IO_COUNTER_RST      12'h018
`define IO_LEDS             12'h030
`define IO_TX_DUTY          12'h034
`define IO_TX               12'h038
`define IO_DAC_SRC          12'h044
`define IO_GSR              12'h100
`define IO_GLOBAL_SHIFT     12'h104
`define IO_WAVE_SHIFT_BASE  12'h200  // sine, square, triangle, sawtooth

// offsets inside a voice window, one of addr[15:12] set
`define IO_VOICE_FCW        12'h000
`define IO_VOICE_START      12'h004
`define IO_VOICE_RELEASE    12'h008
`define IO_VOICE_RESET      12'h010

// memory depths in words, as address widths
`define DMEM_AW             8
`define IMEM_AW             14

`endif

//--- logic/store_pkg.sv
`default_nettype none

`include "store_cfg.svh"

package store_pkg;

    // bus word and byte lanes
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wmask_t;

    // instruction fields seen by the store path
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  funct5_t;

    // one-hot voice select, bit i is voice i
    typedef logic [3:0]  voice_sel_t;

    // waveform and global shift amounts
    typedef logic [4:0]  shift_t;

    // oscillator frequency control word
    typedef logic [23:0] fcw_t;

    // word index into data memory
    typedef logic [`DMEM_AW-1:0] dmem_addr_t;

endpackage

`default_nettype wire

//--- logic/store_lane_align.sv
`timescale 1ns/1ns
`default_nettype none

`include "store_cfg.svh"

module store_lane_align (
    input  wire                      en,
    input  wire store_pkg::funct5_t  funct5,
    input  wire store_pkg::funct3_t  funct3,
    input  wire [1:0]                addr_lo,
    input  wire store_pkg::word_t    rs2,
    output store_pkg::wmask_t        wmask,
    output store_pkg::word_t         wdata
);

    logic is_store;

    assign is_store = en && (funct5 == `OPC_STORE_5);

    always_comb begin
        wmask = 4'b0000;
        wdata = 32'h0000_0000;
        if (is_store) begin
            case (funct3)
                `FNC_SB: begin
                    case (addr_lo)
                        2'b00: begin
                            wmask = 4'b0001;
                            wdata = {24'b0, rs2[7:0]};
                        end
                        2'b01: begin
                            wmask = 4'b0010;
                            wdata = {16'b0, rs2[7:0], 8'b0};
                        end
                        2'b10: begin
                            wmask = 4'b0100;
                            wdata = {8'b0, rs2[7:0], 16'b0};
                        end
                        default: begin
                            wmask = 4'b1000;
                            wdata = {rs2[7:0], 24'b0};
                        end
                    endcase
                end
                `FNC_SH: begin
                    // addr_lo[0] ignored, halfword lands on its pair
                    if (addr_lo[1]) begin
                        wmask = 4'b1100;
                        wdata = {rs2[15:0], 16'b0};
                    end else begin
                        wmask = 4'b0011;
                        wdata = {16'b0, rs2[15:0]};
                    end
                end
                `FNC_SW: begin
                    wmask = 4'b1111;
                    wdata = rs2;
                end
                default: begin
                    wmask = 4'b0000;  // unknown size
                    wdata = 32'h0000_0000;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/mmio_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "store_cfg.svh"

module mmio_decode (
    input  wire store_pkg::word_t    addr,
    input  wire store_pkg::wmask_t   wmask,
    input  wire                      pc30,
    output store_pkg::wmask_t        dmem_wea,
    output store_pkg::wmask_t        imem_wea,
    output logic                     uart_we,
    output logic                     counter_rst,
    output logic                     leds_we,
    output logic                     tx_duty_we,
    output logic                     tx_we,
    output logic                     dac_src_we,
    output logic                     gsr_we,
    output logic                     global_shift_we,
    output logic                     wave_shift_we,
    output logic                     fcw_we,
    output logic                     note_start_we,
    output logic                     note_release_we,
    output logic                     voice_reset_we,
    output logic [1:0]               wave_sel,
    output store_pkg::voice_sel_t    voice_sel
);

    logic        dmem_hit;
    logic        imem_hit;
    logic        io_hit;
    logic        sys_hit;
    logic        voice_hit;
    logic        lane0;
    logic        any_lane;
    logic [11:0] off;

    // word offset compare, byte bits ignored
    function automatic logic off_match(input logic [11:0] a, input logic [11:0] ref_off);
        off_match = (a[11:2] == ref_off[11:2]);
    endfunction

    // regions are exclusive so one store has one target
    assign dmem_hit = addr[`DMEM_BIT] && !addr[`IMEM_BIT] && !addr[`IO_BIT];
    assign imem_hit = addr[`IMEM_BIT] && !addr[`DMEM_BIT] && !addr[`IO_BIT];
    assign io_hit   = addr[`IO_BIT] && !addr[`DMEM_BIT] && !addr[`IMEM_BIT];

    assign dmem_wea = dmem_hit ? wmask : 4'b0000;
    assign imem_wea = (imem_hit && pc30) ? wmask : 4'b0000;

    assign off       = addr[11:0];
    assign lane0     = wmask[0];
    assign any_lane  = |wmask;
    assign sys_hit   = io_hit && (addr[15:12] == 4'b0000);
    assign voice_hit = io_hit && $onehot(addr[15:12]);  // two windows at once is ignored

    assign uart_we         = sys_hit && off_match(off, `IO_UART_TX) && lane0;
    assign counter_rst     = sys_hit && off_match(off, `IO_COUNTER_RST) && any_lane;
    assign leds_we         = sys_hit && off_match(off, `IO_LEDS) && lane0;
    assign tx_duty_we      = sys_hit && off_match(off, `IO_TX_DUTY) && any_lane;
    assign tx_we           = sys_hit && off_match(off, `IO_TX) && any_lane;
    assign dac_src_we      = sys_hit && off_match(off, `IO_DAC_SRC) && lane0;
    assign gsr_we          = sys_hit && off_match(off, `IO_GSR) && any_lane;
    assign global_shift_we = sys_hit && off_match(off, `IO_GLOBAL_SHIFT) && lane0;

    // four shift registers, 0x200..0x20c
    assign wave_shift_we = sys_hit && ({off[11:4], 4'h0} == `IO_WAVE_SHIFT_BASE) && lane0;
    assign wave_sel      = off[3:2];

    assign fcw_we          = voice_hit && off_match(off, `IO_VOICE_FCW) && any_lane;
    assign note_start_we   = voice_hit && off_match(off, `IO_VOICE_START) && any_lane;
    assign note_release_we = voice_hit && off_match(off, `IO_VOICE_RELEASE) && any_lane;
    assign voice_reset_we  = voice_hit && off_match(off, `IO_VOICE_RESET) && any_lane;
    assign voice_sel       = addr[15:12];

endmodule

`default_nettype wire

//--- logic/dmem_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "store_cfg.svh"

module dmem_bank (
    input  wire                         clk,
    input  wire store_pkg::wmask_t      wea,
    input  wire store_pkg::dmem_addr_t  waddr,
    input  wire store_pkg::dmem_addr_t  raddr,
    input  wire store_pkg::word_t       wdata,
    output store_pkg::word_t            rdata
);

    import store_pkg::*;

    word_t mem [0:(1 << `DMEM_AW) - 1];

    // byte lane writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wea[i]) begin
                mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[raddr];  // one cycle read latency
    end

endmodule

`default_nettype wire

//--- logic/synth_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module synth_ctrl_regs (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire store_pkg::word_t        wdata,
    input  wire                          uart_we,
    input  wire                          counter_rst,
    input  wire                          leds_we,
    input  wire                          tx_duty_we,
    input  wire                          tx_we,
    input  wire                          dac_src_we,
    input  wire                          gsr_we,
    input  wire                          global_shift_we,
    input  wire                          wave_shift_we,
    input  wire                          fcw_we,
    input  wire                          note_start_we,
    input  wire                          note_release_we,
    input  wire                          voice_reset_we,
    input  wire [1:0]                    wave_sel,
    input  wire store_pkg::voice_sel_t   voice_sel,
    output logic [7:0]                   leds,
    output store_pkg::word_t             tx_word,
    output store_pkg::word_t             tx_duty,
    output logic [7:0]                   dac_src,
    output logic                         gsr,
    output store_pkg::shift_t            global_shift,
    output store_pkg::shift_t            wave_shift0,
    output store_pkg::shift_t            wave_shift1,
    output store_pkg::shift_t            wave_shift2,
    output store_pkg::shift_t            wave_shift3,
    output store_pkg::fcw_t              voice_fcw0,
    output store_pkg::fcw_t              voice_fcw1,
    output store_pkg::fcw_t              voice_fcw2,
    output store_pkg::fcw_t              voice_fcw3,
    output store_pkg::voice_sel_t        note_start,
    output store_pkg::voice_sel_t        note_release,
    output store_pkg::voice_sel_t        voice_reset,
    output store_pkg::word_t             cycle_count,
    output logic [7:0]                   uart_tx_data,
    output logic                         uart_tx_valid
);

    import store_pkg::*;

    shift_t wave_shift_q [4];
    fcw_t   fcw_q [4];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            leds         <= 8'h00;
            tx_word      <= 32'h0000_0000;
            tx_duty      <= 32'h0000_0000;
            dac_src      <= 8'h00;
            gsr          <= 1'b1;  // oscillators held until released
            global_shift <= 5'd0;
            for (int i = 0; i < 4; i++) begin
                wave_shift_q[i] <= 5'd0;
                fcw_q[i]        <= 24'h00_0000;
            end
        end else begin
            if (leds_we)         leds         <= wdata[7:0];
            if (tx_we)           tx_word      <= wdata;
            if (tx_duty_we)      tx_duty      <= wdata;
            if (dac_src_we)      dac_src      <= wdata[7:0];
            if (gsr_we)          gsr          <= wdata[0];
            if (global_shift_we) global_shift <= wdata[4:0];
            if (wave_shift_we)   wave_shift_q[wave_sel] <= wdata[4:0];
            for (int i = 0; i < 4; i++) begin
                if (fcw_we && voice_sel[i]) begin
                    fcw_q[i] <= wdata[23:0];
                end
            end
        end
    end

    // single cycle voice pulses, counter and uart handoff
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            note_start    <= 4'b0000;
            note_release  <= 4'b0000;
            voice_reset   <= 4'b0000;
            cycle_count   <= 32'h0000_0000;
            uart_tx_data  <= 8'h00;
            uart_tx_valid <= 1'b0;
        end else begin
            note_start    <= note_start_we ? voice_sel : 4'b0000;
            note_release  <= note_release_we ? voice_sel : 4'b0000;
            voice_reset   <= voice_reset_we ? voice_sel : 4'b0000;
            cycle_count   <= counter_rst ? 32'h0000_0000 : cycle_count + 32'd1;
            uart_tx_valid <= uart_we;
            if (uart_we) begin
                uart_tx_data <= wdata[7:0];
            end
        end
    end

    assign wave_shift0 = wave_shift_q[0];  // sine
    assign wave_shift1 = wave_shift_q[1];  // square
    assign wave_shift2 = wave_shift_q[2];  // triangle
    assign wave_shift3 = wave_shift_q[3];  // sawtooth
    assign voice_fcw0  = fcw_q[0];
    assign voice_fcw1  = fcw_q[1];
    assign voice_fcw2  = fcw_q[2];
    assign voice_fcw3  = fcw_q[3];

endmodule

`default_nettype wire

//--- logic/store_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "store_cfg.svh"

module store_subsys_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          st_en,
    input  wire store_pkg::word_t        st_addr,
    input  wire store_pkg::word_t        st_wdata,
    input  wire store_pkg::funct5_t      st_funct5,
    input  wire store_pkg::funct3_t      st_funct3,
    input  wire                          pc30,
    input  wire store_pkg::dmem_addr_t   dmem_raddr,
    output store_pkg::word_t             dmem_rdata,
    output store_pkg::wmask_t            imem_wea,
    output logic [`IMEM_AW-1:0]          imem_waddr,
    output store_pkg::word_t             imem_wdata,
    output logic [7:0]                   leds,
    output store_pkg::word_t             tx_word,
    output store_pkg::word_t             tx_duty,
    output logic [7:0]                   dac_src,
    output logic                         gsr,
    output store_pkg::shift_t            global_shift,
    output store_pkg::shift_t            wave_shift0,
    output store_pkg::shift_t            wave_shift1,
    output store_pkg::shift_t            wave_shift2,
    output store_pkg::shift_t            wave_shift3,
    output store_pkg::fcw_t              voice_fcw0,
    output store_pkg::fcw_t              voice_fcw1,
    output store_pkg::fcw_t              voice_fcw2,
    output store_pkg::fcw_t              voice_fcw3,
    output store_pkg::voice_sel_t        note_start,
    output store_pkg::voice_sel_t        note_release,
    output store_pkg::voice_sel_t        voice_reset,
    output store_pkg::word_t             cycle_count,
    output logic [7:0]                   uart_tx_data,
    output logic                         uart_tx_valid
);

    import store_pkg::*;

    wmask_t     wmask;
    word_t      al_wdata;
    wmask_t     dmem_wea;
    dmem_addr_t dmem_waddr;
    voice_sel_t voice_sel;
    logic [1:0] wave_sel;
    logic       uart_we;
    logic       counter_rst;
    logic       leds_we;
    logic       tx_duty_we;
    logic       tx_we;
    logic       dac_src_we;
    logic       gsr_we;
    logic       global_shift_we;
    logic       wave_shift_we;
    logic       fcw_we;
    logic       note_start_we;
    logic       note_release_we;
    logic       voice_reset_we;

    assign dmem_waddr = st_addr[`DMEM_AW+1:2];
    assign imem_waddr = st_addr[`IMEM_AW+1:2];
    assign imem_wdata = al_wdata;

    store_lane_align u_align (
        .en      (st_en),
        .funct5  (st_funct5),
        .funct3  (st_funct3),
        .addr_lo (st_addr[1:0]),
        .rs2     (st_wdata),
        .wmask   (wmask),
        .wdata   (al_wdata)
    );

    mmio_decode u_decode (
        .addr            (st_addr),
        .wmask           (wmask),
        .pc30            (pc30),
        .dmem_wea        (dmem_wea),
        .imem_wea        (imem_wea),
        .uart_we         (uart_we),
        .counter_rst     (counter_rst),
        .leds_we         (leds_we),
        .tx_duty_we      (tx_duty_we),
        .tx_we           (tx_we),
        .dac_src_we      (dac_src_we),
        .gsr_we          (gsr_we),
        .global_shift_we (global_shift_we),
        .wave_shift_we   (wave_shift_we),
        .fcw_we          (fcw_we),
        .note_start_we   (note_start_we),
        .note_release_we (note_release_we),
        .voice_reset_we  (voice_reset_we),
        .wave_sel        (wave_sel),
        .voice_sel       (voice_sel)
    );

    dmem_bank u_dmem (
        .clk   (clk),
        .wea   (dmem_wea),
        .waddr (dmem_waddr),
        .raddr (dmem_raddr),
        .wdata (al_wdata),
        .rdata (dmem_rdata)
    );

    synth_ctrl_regs u_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .wdata           (al_wdata),
        .uart_we         (uart_we),
        .counter_rst     (counter_rst),
        .leds_we         (leds_we),
        .tx_duty_we      (tx_duty_we),
        .tx_we           (tx_we),
        .dac_src_we      (dac_src_we),
        .gsr_we          (gsr_we),
        .global_shift_we (global_shift_we),
        .wave_shift_we   (wave_shift_we),
        .fcw_we          (fcw_we),
        .note_start_we   (note_start_we),
        .note_release_we (note_release_we),
        .voice_reset_we  (voice_reset_we),
        .wave_sel        (wave_sel),
        .voice_sel       (voice_sel),
        .leds            (leds),
        .tx_word         (tx_word),
        .tx_duty         (tx_duty),
        .dac_src         (dac_src),
        .gsr             (gsr),
        .global_shift    (global_shift),
        .wave_shift0     (wave_shift0),
        .wave_shift1     (wave_shift1),
        .wave_shift2     (wave_shift2),
        .wave_shift3     (wave_shift3),
        .voice_fcw0      (voice_fcw0),
        .voice_fcw1      (voice_fcw1),
        .voice_fcw2      (voice_fcw2),
        .voice_fcw3      (voice_fcw3),
        .note_start      (note_start),
        .note_release    (note_release),
        .voice_reset     (voice_reset),
        .cycle_count     (cycle_count),
        .uart_tx_data    (uart_tx_data),
        .uart_tx_valid   (uart_tx_valid)
    );

endmodule

`default_nettype wire

//--- dv/store_subsys_props.sv
`timescale 1ns/1ns
`default_nettype none

module store_subsys_props (
    input wire                        clk,
    input wire                        rst_n,
    input wire                        pc30,
    input wire store_pkg::wmask_t     dmem_wea,
    input wire store_pkg::wmask_t     imem_wea,
    input wire [12:0]                 io_we,
    input wire store_pkg::voice_sel_t note_start,
    input wire store_pkg::voice_sel_t note_release,
    input wire store_pkg::voice_sel_t voice_reset,
    input wire [7:0]                  leds,
    input wire [7:0]                  dac_src,
    input wire store_pkg::word_t      tx_word,
    input wire store_pkg::word_t      tx_duty,
    input wire store_pkg::word_t      cycle_count,
    input wire                        gsr,
    input wire store_pkg::shift_t     global_shift
);

    int fail_count = 0;  // read by the testbench

    pulse_width: assert property (@(posedge clk) disable iff (!rst_n)
        (note_start | note_release | voice_reset) != 4'b0000 |=>
        (note_start | note_release | voice_reset) == 4'b0000)
        else begin $error("voice pulse held past one cycle"); fail_count++; end

    reset_state: assert property (@(posedge clk) $rose(rst_n) |->
        (leds == 8'h00 && dac_src == 8'h00 && tx_word == 32'h0 && tx_duty == 32'h0 &&
         global_shift == 5'd0 && cycle_count == 32'h0 && gsr &&
         (note_start | note_release | voice_reset) == 4'b0000))
        else begin $error("registers not at reset values"); fail_count++; end

    imem_gate: assert property (@(posedge clk) !pc30 |-> imem_wea == 4'b0000)
        else begin $error("imem write without pc30"); fail_count++; end

    one_target: assert property (@(posedge clk) $onehot0({|dmem_wea, |imem_wea, io_we}))
        else begin $error("store reached more than one target"); fail_count++; end

endmodule

bind store_subsys_top store_subsys_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc30         (pc30),
    .dmem_wea     (dmem_wea),
    .imem_wea     (imem_wea),
    .io_we        ({uart_we, counter_rst, leds_we, tx_duty_we, tx_we, dac_src_we, gsr_we,
                    global_shift_we, wave_shift_we, fcw_we, note_start_we, note_release_we,
                    voice_reset_we}),
    .note_start   (note_start),
    .note_release (note_release),
    .voice_reset  (voice_reset),
    .leds         (leds),
    .dac_src      (dac_src),
    .tx_word      (tx_word),
    .tx_duty      (tx_duty),
    .cycle_count  (cycle_count),
    .gsr          (gsr),
    .global_shift (global_shift)
);

`default_nettype wire

//--- dv/store_subsys_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "store_cfg.svh"

module store_subsys_tb;

    import store_pkg::*;

    localparam int NWORDS = 16;  // dmem words exercised

    logic                clk;
    logic                rst_n;
    logic                st_en;
    logic                pc30;
    word_t               st_addr;
    word_t               st_wdata;
    funct5_t             st_funct5;
    funct3_t             st_funct3;
    dmem_addr_t          dmem_raddr;
    word_t               dmem_rdata, imem_wdata, tx_word, tx_duty, cycle_count;
    wmask_t              imem_wea;
    logic [`IMEM_AW-1:0] imem_waddr;
    logic [7:0]          leds, dac_src, uart_tx_data;
    logic                gsr, uart_tx_valid;
    shift_t              global_shift, wave_shift0, wave_shift1, wave_shift2, wave_shift3;
    fcw_t                voice_fcw0, voice_fcw1, voice_fcw2, voice_fcw3;
    voice_sel_t          note_start, note_release, voice_reset;

    word_t model [NWORDS];      // dmem shadow
    fcw_t  fcw_model [4];
    int    errors, tests_run, tests_ok, err_mark;

    store_subsys_top UUT (.*);

    always #10 clk = ~clk;

    function automatic wmask_t lane_mask(input funct3_t f3, input logic [1:0] lo);
        case (f3)
            `FNC_SB: lane_mask = wmask_t'(1) << lo;
            `FNC_SH: lane_mask = lo[1] ? 4'b1100 : 4'b0011;
            `FNC_SW: lane_mask = 4'b1111;
            default: lane_mask = 4'b0000;
        endcase
    endfunction

    // written lanes take source bytes from byte 0 upward
    function automatic word_t merge_store(input word_t old, input word_t d,
                                          input funct3_t f3, input logic [1:0] lo);
        wmask_t m;
        int     base;
        m = lane_mask(f3, lo);
        if (f3 == `FNC_SB) base = int'(lo);
        else if (f3 == `FNC_SH) base = lo[1] ? 2 : 0;
        else base = 0;
        merge_store = old;
        for (int i = 0; i < 4; i++) begin
            if (m[i]) merge_store[i*8 +: 8] = d[(i-base)*8 +: 8];
        end
    endfunction

    function automatic word_t dmem_byte_addr(input int idx);
        dmem_byte_addr = 32'h1000_0000 | (idx << 2);
    endfunction

    function automatic word_t io_addr(input logic [11:0] off);
        io_addr = 32'h8000_0000 | 32'(off);
    endfunction

    function automatic shift_t wave_shift_of(input int w);
        case (w)
            0: wave_shift_of = wave_shift0;
            1: wave_shift_of = wave_shift1;
            2: wave_shift_of = wave_shift2;
            default: wave_shift_of = wave_shift3;
        endcase
    endfunction

    function automatic fcw_t fcw_of(input int v);
        case (v)
            0: fcw_of = voice_fcw0;
            1: fcw_of = voice_fcw1;
            2: fcw_of = voice_fcw2;
            default: fcw_of = voice_fcw3;
        endcase
    endfunction

    function automatic voice_sel_t pulse_of(input int kind);
        if (kind == 0) pulse_of = note_start;
        else if (kind == 1) pulse_of = note_release;
        else pulse_of = voice_reset;
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_store(input word_t a, input word_t d, input funct3_t f3,
                               input funct5_t f5 = `OPC_STORE_5, input logic en = 1'b1);
        @(posedge clk);
        st_en     <= en;
        st_addr   <= a;
        st_wdata  <= d;
        st_funct5 <= f5;
        st_funct3 <= f3;
    endtask

    task automatic end_store();
        @(posedge clk);
        st_en <= 1'b0;
        @(negedge clk);  // registers settled here
    endtask

    task automatic store(input word_t a, input word_t d, input funct3_t f3,
                         input funct5_t f5 = `OPC_STORE_5, input logic en = 1'b1);
        drive_store(a, d, f3, f5, en);
        end_store();
    endtask

    task automatic read_word(input int idx, output word_t w);
        @(posedge clk);
        dmem_raddr <= dmem_addr_t'(idx);
        @(posedge clk);
        @(negedge clk);
        w = dmem_rdata;
    endtask

    task automatic voice_pulse(input int kind, input voice_sel_t sel);
        word_t      a;
        voice_sel_t exp;
        int         n;
        a = 32'h8000_0000 | {16'h0, sel, 12'h000};
        if (kind == 0) a = a | 32'(`IO_VOICE_START);
        else if (kind == 1) a = a | 32'(`IO_VOICE_RELEASE);
        else a = a | 32'(`IO_VOICE_RESET);
        exp = $onehot(sel) ? sel : 4'b0000;
        drive_store(a, $urandom, `FNC_SW);
        @(posedge clk);
        st_en <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (pulse_of(kind) == 4'b0000 && n < 4);
        if (exp != 4'b0000 && pulse_of(kind) == 4'b0000) begin
            $display("voice pulse %0d never showed up for select %b", kind, sel);
            errors++;
        end else begin
            check("voice pulse", 32'(pulse_of(kind)), 32'(exp));
            if (exp != 4'b0000) check("voice pulse delay", 32'(n), 32'd1);
        end
        @(negedge clk);
        check("voice pulse end", 32'(pulse_of(kind)), 32'h0);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) tests_ok++;
        $display("test %0d %s: %0d error(s)", tests_run, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        word_t      d;
        word_t      w;
        word_t      e;
        int         idx;
        logic [1:0] lo;
        funct3_t    f3;
        void'($urandom(32'h98ff));
        errors     = 0;
        tests_run  = 0;
        tests_ok   = 0;
        err_mark   = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        st_en      = 1'b0;
        pc30       = 1'b0;
        st_addr    = 32'h0;
        st_wdata   = 32'h0;
        st_funct5  = 5'b0;
        st_funct3  = 3'b0;
        dmem_raddr = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < NWORDS; i++) begin  // known contents first
            model[i] = $urandom;
            store(dmem_byte_addr(i), model[i], `FNC_SW);
        end
        repeat (40) begin
            idx = $urandom_range(NWORDS - 1);
            lo  = 2'($urandom);
            f3  = 3'($urandom_range(2));
            d   = $urandom;
            store(dmem_byte_addr(idx) | 32'(lo), d, f3);
            model[idx] = merge_store(model[idx], d, f3, lo);
        end
        for (int i = 0; i < NWORDS; i++) begin
            read_word(i, w);
            check("dmem_rdata", w, model[i]);
        end
        finish_test("dmem sb/sh/sw");

        for (int k = 0; k < 3; k++) begin
            f3 = (k == 2) ? 3'b011 : `FNC_SW;
            store(dmem_byte_addr(3), $urandom, f3, (k == 1) ? 5'b00000 : `OPC_STORE_5, k != 0);
            store(io_addr(`IO_LEDS), $urandom, f3, (k == 1) ? 5'b00000 : `OPC_STORE_5, k != 0);
        end
        read_word(3, w);
        check("dmem_rdata", w, model[3]);
        check("leds", 32'(leds), 32'h0);
        finish_test("non-stores");

        d = $urandom;
        drive_store(32'h2000_0008, d, `FNC_SW);
        @(negedge clk);
        check("imem_wea", 32'(imem_wea), 32'h0);  // pc30 low
        end_store();
        @(posedge clk);
        pc30 <= 1'b1;
        drive_store(32'h2000_000a, d, `FNC_SH);
        @(negedge clk);
        check("imem_wea", 32'(imem_wea), 32'(lane_mask(`FNC_SH, 2'b10)));
        check("imem_wdata", imem_wdata, merge_store(32'h0, d, `FNC_SH, 2'b10));
        check("imem_waddr", 32'(imem_waddr), 32'd2);
        end_store();
        @(posedge clk);
        pc30 <= 1'b0;
        read_word(2, w);
        check("dmem_rdata", w, model[2]);
        check("uart_tx_data", 32'(uart_tx_data), 32'h0);  // offset 0x008 aliases uart
        finish_test("imem gating");

        d = $urandom;
        store(io_addr(`IO_LEDS), d, `FNC_SW);
        check("leds", 32'(leds), 32'(d[7:0]));
        store(io_addr(`IO_LEDS) | 32'd1, ~d, `FNC_SB);  // lane 1 only
        check("leds", 32'(leds), 32'(d[7:0]));
        store(io_addr(`IO_DAC_SRC), d, `FNC_SW);
        check("dac_src", 32'(dac_src), 32'(d[7:0]));
        store(io_addr(`IO_GSR), 32'h0, `FNC_SW);
        check("gsr", 32'(gsr), 32'h0);
        store(io_addr(`IO_GLOBAL_SHIFT), d, `FNC_SW);
        check("global_shift", 32'(global_shift), 32'(d[4:0]));
        store(io_addr(`IO_GLOBAL_SHIFT) | 32'd2, ~d, `FNC_SH);
        check("global_shift", 32'(global_shift), 32'(d[4:0]));
        for (int k = 0; k < 4; k++) begin
            e = d + word_t'(k * 7);
            store(io_addr(`IO_WAVE_SHIFT_BASE) + word_t'(4 * k), e, `FNC_SW);
            check("wave_shift", 32'(wave_shift_of(k)), 32'(e[4:0]));
        end
        store(io_addr(`IO_TX), d, `FNC_SW);
        check("tx_word", tx_word, d);
        store(io_addr(`IO_TX_DUTY) | 32'd2, d, `FNC_SH);
        check("tx_duty", tx_duty, merge_store(32'h0, d, `FNC_SH, 2'b10));
        store(io_addr(`IO_UART_TX), d, `FNC_SW);
        check("uart_tx_valid", 32'(uart_tx_valid), 32'h1);
        check("uart_tx_data", 32'(uart_tx_data), 32'(d[7:0]));
        @(negedge clk);
        check("uart_tx_valid", 32'(uart_tx_valid), 32'h0);
        store(io_addr(`IO_UART_TX) | 32'd1, ~d, `FNC_SB);  // lane 1 only
        check("uart_tx_valid", 32'(uart_tx_valid), 32'h0);
        check("uart_tx_data", 32'(uart_tx_data), 32'(d[7:0]));
        finish_test("io registers");

        for (int v = 0; v < 4; v++) begin
            d = $urandom;
            store(32'h8000_0000 | (32'h1 << (12 + v)) | 32'(`IO_VOICE_FCW), d, `FNC_SW);
            fcw_model[v] = d[23:0];
            check("voice_fcw", 32'(fcw_of(v)), 32'(fcw_model[v]));
            for (int k = 0; k < 3; k++) voice_pulse(k, voice_sel_t'(1 << v));
        end
        store(32'h8000_3000, $urandom, `FNC_SW);  // two windows at once
        for (int v = 0; v < 4; v++) check("voice_fcw", 32'(fcw_of(v)), 32'(fcw_model[v]));
        voice_pulse(0, 4'b0011);
        finish_test("voices");

        store(io_addr(`IO_COUNTER_RST), $urandom, `FNC_SW);
        check("cycle_count", cycle_count, 32'h0);
        for (int k = 1; k <= 4; k++) begin
            @(negedge clk);
            check("cycle_count", cycle_count, word_t'(k));
        end
        finish_test("cycle counter");

        errors += UUT.u_props.fail_count;
        $display("%0d tests run, %0d clean, %0d errors", tests_run, tests_ok, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
logic/store_pkg.sv
logic/store_lane_align.sv
logic/mmio_decode.sv
logic/dmem_bank.sv
logic/synth_ctrl_regs.sv
logic/store_subsys_top.sv
dv/store_subsys_props.sv
dv/store_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the store subsystem testbench with Verilator, run it, grade the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
: > sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module store_subsys_tb \
    -o store_sim \
    && ./obj_dir/store_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "build or run ended with an error" >> sim.log

cat sim.log

grep -qx "Test passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }

exit 0
